// File: lcd_video.f
hdl/lcd_pkg.sv
hdl/scan_counter.sv
hdl/bg_fetch.sv
hdl/line_buffer.sv
hdl/pixel_out.sv
hdl/lcd_video.sv
bench/lcd_video_chk.sv
bench/lcd_video_monitor.sv
bench/lcd_video_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the lcd_video testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
	--top-module lcd_video_tb \
	-f lcd_video.f \
	-o lcd_video_sim \
	&& ./obj_dir/lcd_video_sim | tee sim.log \
	|| { echo "Build or run failed"; exit 1; }

grep -q "\*\*\* TEST PASSED \*\*\*" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: bench/lcd_video_stimulus.txt
# vram <addr hex> <data hex> | frame <n> <lcdc hex> <scroll_y hex> <scroll_x hex>
# check <frame> <scaled line> <scaled col> <rgb hex>
vram 1800 01
vram 1801 02
vram 1010 55
vram 1011 33
vram 1012 ff
vram 1013 00
vram 1020 00
vram 1021 ff
vram 1c22 05
vram 1c42 06
vram 0058 0f
vram 0059 f0
vram 0060 ff
vram 0061 ff
frame 1 80 00 00
frame 2 98 0c 10
frame 3 00 00 00
check 1 0 0 c0b0b0
check 1 0 3 908080
check 1 0 4 908080
check 1 0 5 908080
check 1 0 6 605050
check 1 1 9 302020
check 1 2 9 302020
check 1 3 0 908080
check 1 0 24 605050
check 1 0 481 236467
check 1 435 30 236467
check 2 0 0 605050
check 2 0 12 908080
check 2 12 0 302020
check 3 0 0 c0b0b0
check 3 100 200 c0b0b0
check 3 438 10 236467

// File: bench/lcd_video_tb.sv
// Top-level testbench for lcd_video.
// Generates the sync timing, models VRAM and loads VRAM contents, per-frame
// control and checkpoints from the stimulus file.
`timescale 1ns/1ns

module lcd_video_tb
	import lcd_pkg::*;
;

	localparam int SCALE = 3;
	localparam int MAX_CHECKS = 32;
	localparam int NUM_FRAMES = 3;
	localparam int HSYNC_LEN = 8;
	localparam int DE_LEN = 520;
	localparam int LINE_LEN = 536;
	localparam int VSYNC_LINES = 2;
	localparam int ACTIVE_LINES = 444;
	localparam longint FRAME_CYCLES = (VSYNC_LINES + ACTIVE_LINES) * LINE_LEN;
	localparam longint WATCHDOG_NS = (NUM_FRAMES * FRAME_CYCLES * 2 + 100) * 8;

	logic        clk_hdmi;
	logic        rst;
	logic        de;
	logic        hsync;
	logic        vsync;
	lcd_ctrl_t   ctrl;
	lcd_ctrl_t   next_ctrl;
	vram_addr_u  vram_addr;
	logic        vram_rd;
	logic [7:0]  vram_data;
	logic [23:0] rgb;
	logic [1:0]  mode;
	logic [7:0]  lcd_v;
	logic        finished;
	int          fail_count;
	int          num_checks;
	logic [63:0] checks [MAX_CHECKS];
	logic [7:0]  vram_mem [8192];
	lcd_ctrl_t   frame_ctrl [NUM_FRAMES + 1];

	lcd_video #(
		.SCALE(SCALE)
	) u_lcd_video (
		.clk_hdmi  (clk_hdmi),
		.rst       (rst),
		.de        (de),
		.hsync     (hsync),
		.vsync     (vsync),
		.ctrl      (ctrl),
		.vram_addr (vram_addr),
		.vram_rd   (vram_rd),
		.vram_data (vram_data),
		.rgb       (rgb),
		.mode      (mode),
		.lcd_v     (lcd_v)
	);

	lcd_video_monitor #(
		.SCALE(SCALE),
		.MAX_CHECKS(MAX_CHECKS)
	) u_lcd_video_monitor (
		.clk_hdmi   (clk_hdmi),
		.rst        (rst),
		.de         (de),
		.hsync      (hsync),
		.vsync      (vsync),
		.ctrl       (ctrl),
		.rgb        (rgb),
		.mode       (mode),
		.lcd_v      (lcd_v),
		.num_checks (num_checks),
		.checks     (checks),
		.finished   (finished),
		.fail_count (fail_count)
	);

	initial clk_hdmi = 1'b0;
	always #4 clk_hdmi = ~clk_hdmi;

	// VRAM with one cycle of read latency
	always @(posedge clk_hdmi) begin
		if (vram_rd)
			vram_data <= vram_mem[vram_addr];
	end

	task automatic load_stimulus(output logic ok);
		int fd;
		int n;
		int f;
		int a;
		int d;
		int row;
		int col;
		int lcdc;
		int sy;
		int sx;
		string line;
		string kind;
		ok = 1'b0;
		fd = $fopen("bench/lcd_video_stimulus.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				kind = "";
				if (n > 0 && $sscanf(line, "%s", kind) == 1) begin
					if (kind == "vram" && $sscanf(line, "%s %h %h", kind, a, d) == 3) begin
						vram_mem[a[12:0]] = d[7:0];
					end else if (kind == "frame" &&
						$sscanf(line, "%s %d %h %h %h", kind, f, lcdc, sy, sx) == 5) begin
						frame_ctrl[f] = '{lcdc: lcdc[7:0], scroll_y: sy[7:0], scroll_x: sx[7:0]};
					end else if (kind == "check" && num_checks < MAX_CHECKS &&
						$sscanf(line, "%s %d %d %d %h", kind, f, row, col, d) == 5) begin
						checks[num_checks] = {8'h0, f[7:0], row[11:0], col[11:0], d[23:0]};
						num_checks = num_checks + 1;
					end
				end
			end
			$fclose(fd);
			ok = 1'b1;
		end
	endtask

	// One line of hsync pulse, back porch and de cycles
	task automatic run_line(input logic vs, input logic en);
		for (int i = 0; i < LINE_LEN; i++) begin
			@(posedge clk_hdmi);
			if (i == 0) begin
				vsync <= vs;
				ctrl <= next_ctrl;
			end
			hsync <= (i >= HSYNC_LEN);
			de <= en && (i >= LINE_LEN - DE_LEN);
		end
	endtask

	task automatic run_frame(input int f);
		next_ctrl = frame_ctrl[f];
		for (int l = 0; l < VSYNC_LINES; l++)
			run_line(1'b0, 1'b0);
		for (int l = 0; l < ACTIVE_LINES; l++)
			run_line(1'b1, 1'b1);
	endtask

	initial begin
		logic loaded;
		rst = 1'b1;
		de = 1'b0;
		hsync = 1'b1;
		vsync = 1'b1;
		ctrl = '0;
		vram_data = '0;
		next_ctrl = '0;
		finished = 1'b0;
		num_checks = 0;
		void'($urandom(32'hf6c0_4723));
		for (int a = 0; a < 8192; a++)
			vram_mem[a] = 8'($urandom);
		for (int f = 0; f <= NUM_FRAMES; f++)
			frame_ctrl[f] = '0;
		load_stimulus(loaded);
		if (!loaded) begin
			$display("Cannot open the stimulus file");
			$display("*** TEST FAILED ***");
			$finish;
		end else begin
			repeat (10) @(posedge clk_hdmi);
			rst <= 1'b0;
			for (int f = 1; f <= NUM_FRAMES; f++)
				run_frame(f);
			@(posedge clk_hdmi);
			finished <= 1'b1;
			repeat (3) @(posedge clk_hdmi);
			if (fail_count == 0)
				$display("*** TEST PASSED ***");
			else
				$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial begin
		#WATCHDOG_NS;
		$display("Watchdog expired before the frames finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: bench/lcd_video_monitor.sv
// Watches the lcd_video ports and compares rgb and lcd_v at each checkpoint.
// Tracks the scaled screen position from de, hsync and vsync on its own.
`timescale 1ns/1ns

module lcd_video_monitor
	import lcd_pkg::*;
#(
	parameter int SCALE = 3,
	parameter int MAX_CHECKS = 32
) (
	input  logic        clk_hdmi,
	input  logic        rst,
	input  logic        de,
	input  logic        hsync,
	input  logic        vsync,
	input  lcd_ctrl_t   ctrl,
	input  logic [23:0] rgb,
	input  logic [1:0]  mode,
	input  logic [7:0]  lcd_v,
	input  int          num_checks,
	input  logic [63:0] checks [MAX_CHECKS],
	input  logic        finished,
	output int          fail_count
);

	int frame;
	int sl;
	int sc;
	logic vsync_q;
	logic hit [MAX_CHECKS];
	logic pend_valid;
	int pend_idx;
	int passed;
	int failed;
	int mode_errs;
	logic reported;

	initial begin
		for (int k = 0; k < MAX_CHECKS; k++)
			hit[k] = 1'b0;
		fail_count = 0;
		passed = 0;
		failed = 0;
		mode_errs = 0;
		reported = 1'b0;
	end

	always @(posedge clk_hdmi) begin
		int missed;
		if (rst) begin
			frame <= 0;
			sl <= 0;
			sc <= 0;
			vsync_q <= 1'b1;
			pend_valid <= 1'b0;
		end else begin
			vsync_q <= vsync;
			pend_valid <= 1'b0;
			// rgb of the previous de cycle is on the port now
			if (pend_valid) begin
				if (rgb == checks[pend_idx][23:0]) begin
					passed = passed + 1;
					$display("PASS frame %0d line %0d col %0d rgb %h",
						checks[pend_idx][55:48], checks[pend_idx][47:36],
						checks[pend_idx][35:24], rgb);
				end else begin
					failed = failed + 1;
					$display("[ERROR] rgb frame %0d line %0d col %0d: expected %h, got %h",
						checks[pend_idx][55:48], checks[pend_idx][47:36],
						checks[pend_idx][35:24], checks[pend_idx][23:0], rgb);
				end
			end
			if (vsync_q && !vsync)
				frame <= frame + 1;
			if (!vsync || !ctrl.lcdc[7]) begin
				if (mode != MODE_VBLANK) begin
					mode_errs = mode_errs + 1;
					if (mode_errs < 5)
						$display("[ERROR] mode frame %0d: expected %h, got %h",
							frame, MODE_VBLANK, mode);
				end
			end
			if (!vsync) begin
				sl <= 0;
				sc <= 0;
			end else if (!hsync) begin
				if (sc != 0)
					sl <= sl + 1;
				sc <= 0;
			end else if (de) begin
				for (int i = 0; i < num_checks; i++) begin
					if (int'(checks[i][55:48]) == frame && int'(checks[i][47:36]) == sl &&
						int'(checks[i][35:24]) == sc) begin
						hit[i] = 1'b1;
						pend_valid <= 1'b1;
						pend_idx <= i;
						if (lcd_v != 8'(sl / SCALE)) begin
							failed = failed + 1;
							$display("[ERROR] lcd_v frame %0d line %0d: expected %h, got %h",
								frame, sl, 8'(sl / SCALE), lcd_v);
						end
					end
				end
				sc <= sc + 1;
			end
		end
		if (finished && !reported) begin
			missed = 0;
			for (int i = 0; i < num_checks; i++) begin
				if (!hit[i]) begin
					missed = missed + 1;
					$display("Checkpoint frame %0d line %0d col %0d was never reached",
						checks[i][55:48], checks[i][47:36], checks[i][35:24]);
				end
			end
			$display("Checks: %0d passed, %0d failed, %0d missed, %0d mode errors",
				passed, failed, missed, mode_errs);
			fail_count = failed + missed + mode_errs;
			reported = 1'b1;
		end
	end

endmodule

// File: bench/lcd_video_chk.sv
// Concurrent assertions on the lcd_video top level.
// Bound into every lcd_video instance.
`timescale 1ns/1ns

module lcd_video_chk
	import lcd_pkg::*;
(
	input logic        clk_hdmi,
	input logic        rst,
	input logic        de,
	input logic        vsync,
	input logic [23:0] rgb,
	input logic [1:0]  mode,
	input logic        vram_rd,
	input logic [4:0]  wr_idx,
	input logic        fetch_req
);

	// Cycles since the last accepted fetch request, held at 1000
	int   since_start;
	logic req_q;

	always_ff @(posedge clk_hdmi or posedge rst) begin
		if (rst) begin
			req_q <= 1'b0;
			since_start <= 1000;
		end else begin
			req_q <= fetch_req;
			// An accepted request reads the map on the next cycle
			if (req_q && vram_rd)
				since_start <= 2;
			else if (since_start < 1000)
				since_start <= since_start + 1;
		end
	end

	// Reads in mode 01 only belong to the line 0 fetch during vsync
	a_no_read_in_vblank: assert property (@(posedge clk_hdmi) disable iff (rst)
		vram_rd && vsync |-> mode != MODE_VBLANK)
		else $error("VRAM read in mode 01 outside vsync");

	a_wr_idx_range: assert property (@(posedge clk_hdmi) disable iff (rst)
		wr_idx < 5'd20)
		else $error("Line buffer index out of range");

	// A line fetch stays busy for 120 cycles after its request
	a_req_not_busy: assert property (@(posedge clk_hdmi) disable iff (rst)
		fetch_req |-> !req_q && since_start > 120)
		else $error("Fetch request while a fetch is busy");

	a_blank_rgb: assert property (@(posedge clk_hdmi) disable iff (rst)
		!de |=> rgb == 24'h0)
		else $error("RGB not zero after a blanking cycle");

endmodule

bind lcd_video lcd_video_chk u_lcd_video_chk (.*);

// File: hdl/lcd_video.sv
// Top level of the scan-line LCD video block.
// Builds each background line from VRAM into a ping-pong buffer and streams
// it out scaled by SCALE; sync and de timing come from outside.
`timescale 1ns/1ns

module lcd_video
	import lcd_pkg::*;
#(
	parameter int SCALE = 3
) (
	input  logic        clk_hdmi,
	input  logic        rst,
	input  logic        de,
	input  logic        hsync,
	input  logic        vsync,
	input  lcd_ctrl_t   ctrl,
	output vram_addr_u  vram_addr,
	output logic        vram_rd,
	input  logic [7:0]  vram_data,
	output logic [23:0] rgb,
	output logic [1:0]  mode,
	output logic [7:0]  lcd_v
);

	scan_pos_t  pos;
	logic       fetch_req;
	logic [7:0] fetch_row;

	// Write side shared by all banks
	logic       wr_en;
	logic       wr_bank;
	logic [4:0] wr_idx;
	line_word_t wr_word;

	logic [4:0] rd_idx;
	line_word_t [NUM_LINE_BUFS-1:0] bank_words;

	scan_counter #(
		.SCALE(SCALE)
	) u_scan_counter (
		.clk_hdmi  (clk_hdmi),
		.rst       (rst),
		.de        (de),
		.hsync     (hsync),
		.vsync     (vsync),
		.pos       (pos),
		.fetch_req (fetch_req),
		.fetch_row (fetch_row),
		.lcd_v     (lcd_v)
	);

	bg_fetch u_bg_fetch (
		.clk_hdmi  (clk_hdmi),
		.rst       (rst),
		.ctrl      (ctrl),
		.pos       (pos),
		.fetch_req (fetch_req),
		.fetch_row (fetch_row),
		.vram_addr (vram_addr),
		.vram_rd   (vram_rd),
		.vram_data (vram_data),
		.wr_en     (wr_en),
		.wr_bank   (wr_bank),
		.wr_idx    (wr_idx),
		.wr_word   (wr_word),
		.mode      (mode)
	);

	for (genvar i = 0; i < NUM_LINE_BUFS; i++) begin : g_bank
		line_buffer #(
			.BANK_ID(i)
		) u_line_buffer (
			.clk_hdmi (clk_hdmi),
			.wr_en    (wr_en),
			.wr_bank  (wr_bank),
			.wr_idx   (wr_idx),
			.wr_word  (wr_word),
			.rd_idx   (rd_idx),
			.rd_word  (bank_words[i])
		);
	end

	pixel_out u_pixel_out (
		.clk_hdmi   (clk_hdmi),
		.rst        (rst),
		.ctrl       (ctrl),
		.pos        (pos),
		.de         (de),
		.bank_words (bank_words),
		.rd_idx     (rd_idx),
		.rgb        (rgb)
	);

endmodule

// File: hdl/pixel_out.sv
// Output stage: picks the shown bank, decodes the shade and maps it to RGB.
// The pixel of a de cycle leaves on the following cycle.
`timescale 1ns/1ns

module pixel_out
	import lcd_pkg::*;
(
	input  logic                            clk_hdmi,
	input  logic                            rst,
	input  lcd_ctrl_t                       ctrl,
	input  scan_pos_t                       pos,
	input  logic                            de,
	input  line_word_t [NUM_LINE_BUFS-1:0]  bank_words,
	output logic [4:0]                      rd_idx,
	output logic [23:0]                     rgb
);

	line_word_t  word;
	logic [2:0]  px;
	logic [1:0]  shade;
	logic [23:0] rgb_next;

	assign rd_idx = pos.col[7:3];
	assign word = bank_words[pos.disp_bank];

	// Bit 7 is the leftmost pixel of a tile
	assign px = 3'd7 - pos.col[2:0];
	assign shade = {word.hi_plane[px], word.lo_plane[px]};

	always_comb begin
		if (!de)
			rgb_next = '0;
		else if (pos.row >= 8'(LCD_H) || pos.col >= 8'(LCD_W))
			rgb_next = COLOR_OFF;
		else if (!ctrl.lcdc[7])
			rgb_next = PALETTE[0];
		else
			rgb_next = PALETTE[shade];
	end

	always_ff @(posedge clk_hdmi or posedge rst) begin
		if (rst)
			rgb <= '0;
		else
			rgb <= rgb_next;
	end

endmodule

// File: hdl/line_buffer.sv
// One bank of the ping-pong line buffer, a tile-row word per tile.
// Instantiated once per bank; only writes tagged with its own bank land here.
`timescale 1ns/1ns

module line_buffer
	import lcd_pkg::*;
#(
	parameter int BANK_ID = 0
) (
	input  logic       clk_hdmi,
	input  logic       wr_en,
	input  logic       wr_bank,
	input  logic [4:0] wr_idx,
	input  line_word_t wr_word,
	input  logic [4:0] rd_idx,
	output line_word_t rd_word
);

	line_word_t mem [TILES_PER_LINE];

	always_ff @(posedge clk_hdmi) begin
		if (wr_en && wr_bank == 1'(BANK_ID) && wr_idx < 5'(TILES_PER_LINE))
			mem[wr_idx] <= wr_word;
	end

	// Column 160 points one past the last tile
	assign rd_word = (rd_idx < 5'(TILES_PER_LINE)) ? mem[rd_idx] : '0;

endmodule

// File: hdl/bg_fetch.sv
// Background tile fetcher.
// On each fetch request it reads map entry, low and high pattern bytes for
// all 20 tiles of a line and writes them into the back line buffer.
`timescale 1ns/1ns

module bg_fetch
	import lcd_pkg::*;
(
	input  logic       clk_hdmi,
	input  logic       rst,
	input  lcd_ctrl_t  ctrl,
	input  scan_pos_t  pos,
	input  logic       fetch_req,
	input  logic [7:0] fetch_row,
	output vram_addr_u vram_addr,
	output logic       vram_rd,
	input  logic [7:0] vram_data,
	output logic       wr_en,
	output logic       wr_bank,
	output logic [4:0] wr_idx,
	output line_word_t wr_word,
	output logic [1:0] mode
);

	// Six cycles per tile, VRAM data arrives one cycle after the address
	typedef enum logic [2:0] {
		S_IDLE,
		S_MAP,
		S_IDX,
		S_LO,
		S_HI,
		S_HID,
		S_WR
	} fetch_state_t;

	fetch_state_t state;
	logic [4:0] tile;
	logic       bank_q;
	logic [7:0] row_q;
	logic [7:0] tile_idx;
	logic [7:0] lo_q;
	logic [7:0] hi_q;
	logic [7:0] y_sum;
	logic       start;

	// Rows past the visible area are not worth fetching
	assign start = fetch_req && ctrl.lcdc[7] && (fetch_row < 8'(LCD_H));
	assign y_sum = row_q + ctrl.scroll_y;

	always_ff @(posedge clk_hdmi or posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
			tile <= '0;
			bank_q <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (start) begin
						state <= S_MAP;
						tile <= '0;
						bank_q <= ~pos.disp_bank;
					end
				end
				S_MAP: state <= S_IDX;
				S_IDX: state <= S_LO;
				S_LO: state <= S_HI;
				S_HI: state <= S_HID;
				S_HID: state <= S_WR;
				S_WR: begin
					if (tile == 5'(TILES_PER_LINE - 1)) begin
						state <= S_IDLE;
					end else begin
						tile <= tile + 5'd1;
						state <= S_MAP;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_hdmi) begin
		if (state == S_IDLE && start)
			row_q <= fetch_row;
		if (state == S_IDX)
			tile_idx <= vram_data;
		if (state == S_HI)
			lo_q <= vram_data;
		if (state == S_HID)
			hi_q <= vram_data;
	end

	always_comb begin
		vram_addr = '0;
		vram_rd = 1'b0;
		case (state)
			S_MAP: begin
				vram_addr.map.area = ctrl.lcdc[3] ? 3'd7 : 3'd6;
				vram_addr.map.tile_row = y_sum[7:3];
				// Wraps around the 32-tile map width
				vram_addr.map.tile_col = ctrl.scroll_x[7:3] + tile;
				vram_rd = 1'b1;
			end
			S_LO, S_HI: begin
				vram_addr.pat.half = ~ctrl.lcdc[4];
				vram_addr.pat.tile_idx = tile_idx;
				vram_addr.pat.line = y_sum[2:0];
				vram_addr.pat.plane = (state == S_HI);
				vram_rd = 1'b1;
			end
			default: begin
				vram_rd = 1'b0;
			end
		endcase
	end

	assign wr_en = (state == S_WR);
	assign wr_bank = bank_q;
	assign wr_idx = tile;
	assign wr_word = '{hi_plane: hi_q, lo_plane: lo_q};

	// pos.active is already low while vsync is low
	always_comb begin
		if (!ctrl.lcdc[7] || !pos.active)
			mode = MODE_VBLANK;
		else if (state != S_IDLE)
			mode = MODE_FETCH;
		else
			mode = MODE_HBLANK;
	end

endmodule

// File: hdl/scan_counter.sv
// Beam position tracker for the scaled LCD picture.
// Follows de, hsync and vsync and asks bg_fetch for the next line in time.
`timescale 1ns/1ns

module scan_counter
	import lcd_pkg::*;
#(
	parameter int SCALE = 3
) (
	input  logic       clk_hdmi,
	input  logic       rst,
	input  logic       de,
	input  logic       hsync,
	input  logic       vsync,
	output scan_pos_t  pos,
	output logic       fetch_req,
	output logic [7:0] fetch_row,
	output logic [7:0] lcd_v
);

	localparam logic [1:0] REP_LAST = 2'(SCALE - 1);
	localparam logic [7:0] COL_LAST = 8'(LCD_W - 1);
	localparam logic [7:0] ROW_HOLD = 8'd153;

	logic [7:0] row;
	logic [7:0] col;
	logic [1:0] row_rep;
	logic [1:0] col_rep;
	logic       disp_bank;
	logic       vsync_q;
	logic       line_end;

	assign line_end = vsync && hsync && de && col == COL_LAST &&
		col_rep == REP_LAST && row_rep == REP_LAST;

	always_ff @(posedge clk_hdmi or posedge rst) begin
		if (rst) begin
			row <= '0;
			col <= '0;
			row_rep <= '0;
			col_rep <= '0;
		end else if (!vsync) begin
			row <= '0;
			col <= '0;
			row_rep <= '0;
			col_rep <= '0;
		end else if (!hsync) begin
			col <= '0;
			col_rep <= '0;
		end else if (de) begin
			if (col_rep == REP_LAST) begin
				col_rep <= '0;
				// Sits at 160 until hsync clears it
				if (col != 8'(LCD_W))
					col <= col + 8'd1;
				if (col == COL_LAST) begin
					if (row_rep == REP_LAST) begin
						row_rep <= '0;
						if (row != ROW_HOLD)
							row <= row + 8'd1;
					end else begin
						row_rep <= row_rep + 2'd1;
					end
				end
			end else begin
				col_rep <= col_rep + 2'd1;
			end
		end
	end

	always_ff @(posedge clk_hdmi or posedge rst) begin
		if (rst) begin
			vsync_q <= 1'b1;
			disp_bank <= 1'b0;
			fetch_req <= 1'b0;
			fetch_row <= '0;
		end else begin
			vsync_q <= vsync;
			fetch_req <= 1'b0;
			if (vsync_q && !vsync) begin
				fetch_req <= 1'b1;
				fetch_row <= '0;
			end else if (!vsync_q && vsync) begin
				// Line 0 goes on screen, line 1 is built behind it
				disp_bank <= ~disp_bank;
				fetch_req <= 1'b1;
				fetch_row <= 8'd1;
			end else if (line_end) begin
				disp_bank <= ~disp_bank;
				fetch_req <= 1'b1;
				fetch_row <= row + 8'd2;
			end
		end
	end

	assign pos = '{
		row: row,
		col: col,
		row_rep: row_rep,
		col_rep: col_rep,
		disp_bank: disp_bank,
		active: vsync && (row < 8'(LCD_H))
	};
	assign lcd_v = row;

endmodule

// File: hdl/lcd_pkg.sv
// Shared types and constants for the LCD scan-line video block.
// Modules take these by a wildcard import of lcd_pkg in their header.

package lcd_pkg;

	// Screen geometry in source pixels
	localparam int LCD_W = 160;
	localparam int LCD_H = 144;
	localparam int TILES_PER_LINE = 20;
	localparam int NUM_LINE_BUFS = 2;

	// Shades 0 to 3, lightest first
	localparam logic [3:0][23:0] PALETTE = {
		24'h302020,
		24'h605050,
		24'h908080,
		24'hC0B0B0
	};
	localparam logic [23:0] COLOR_OFF = 24'h236467;

	localparam logic [1:0] MODE_HBLANK = 2'b00;
	localparam logic [1:0] MODE_VBLANK = 2'b01;
	localparam logic [1:0] MODE_FETCH = 2'b11;

	// lcdc bit 7 display on, bit 4 pattern area, bit 3 map area
	typedef struct packed {
		logic [7:0] lcdc;
		logic [7:0] scroll_y;
		logic [7:0] scroll_x;
	} lcd_ctrl_t;

	typedef struct packed {
		logic [7:0] row;
		logic [7:0] col;
		logic [1:0] row_rep;
		logic [1:0] col_rep;
		logic       disp_bank;
		logic       active;
	} scan_pos_t;

	// Background map entry, 0x1800 or 0x1C00 based
	typedef struct packed {
		logic [2:0] area;
		logic [4:0] tile_row;
		logic [4:0] tile_col;
	} map_addr_t;

	// Tile pattern byte, 16 bytes per tile
	typedef struct packed {
		logic       half;
		logic [7:0] tile_idx;
		logic [2:0] line;
		logic       plane;
	} pat_addr_t;

	typedef union packed {
		map_addr_t map;
		pat_addr_t pat;
	} vram_addr_u;

	typedef struct packed {
		logic [7:0] hi_plane;
		logic [7:0] lo_plane;
	} line_word_t;

endpackage
